// ==== filelist.f ====
+incdir+hw
hw/icache_pkg.sv
hw/way_array.sv
hw/icache_ctrl.sv
hw/icache.sv
hw/mem_arbiter.sv
hw/fetch_top.sv
verif/fetch_tb.sv

// ==== hw/fetch_top.sv ====
`default_nettype none

`include "icache_macros.svh"

module fetch_top (
    input  logic                         clk,
    input  logic                         rst,

    input  logic [`ICACHE_NUM_PORTS-1:0] read,
    input  logic [`ICACHE_NUM_PORTS-1:0] kill,
    input  logic [31:0]                  addr [`ICACHE_NUM_PORTS],
    output logic [`ICACHE_NUM_PORTS-1:0] stall,
    output icache_pkg::word_t            rdata [`ICACHE_NUM_PORTS],

    output icache_pkg::mem_req_t         mem_req,
    input  logic                         mem_ready,
    input  icache_pkg::mem_resp_t        mem_resp
);

    icache_pkg::mem_req_t         cache_req [`ICACHE_NUM_PORTS];
    logic [`ICACHE_NUM_PORTS-1:0] cache_ready;

    for (genvar p = 0; p < `ICACHE_NUM_PORTS; p++) begin : g_port
        icache cache_i (
            .clk      (clk),
            .rst      (rst),
            .read     (read[p]),
            .kill     (kill[p]),
            .addr     (addr[p]),
            .stall    (stall[p]),
            .rdata    (rdata[p]),
            .mem_req  (cache_req[p]),
            .mem_ready(cache_ready[p]),
            .mem_resp (mem_resp) // broadcast to every port.
        );
    end

    mem_arbiter arb_i (
        .clk      (clk),
        .rst      (rst),
        .req_in   (cache_req),
        .ready_out(cache_ready),
        .mem_req  (mem_req),
        .mem_ready(mem_ready)
    );

endmodule

`default_nettype wire

// ==== hw/icache.sv ====
`default_nettype none

`include "icache_macros.svh"

module icache (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  read,
    input  logic                  kill,
    input  logic [31:0]           addr,
    output logic                  stall,
    output icache_pkg::word_t     rdata,

    output icache_pkg::mem_req_t  mem_req,
    input  logic                  mem_ready,
    input  icache_pkg::mem_resp_t mem_resp
);

    logic [`ICACHE_TAG_BITS-1:0]      tag;
    logic [`ICACHE_SET_BITS-1:0]      set;
    logic [`ICACHE_OFFSET_BITS-3:0]   word_sel;

    icache_pkg::tag_entry_t           tag_entries [`ICACHE_NUM_WAYS];
    icache_pkg::line_t                data_entries [`ICACHE_NUM_WAYS];
    icache_pkg::tag_entry_t           fill_tag;

    logic                             allocate_done;
    logic                             hit;
    logic [`ICACHE_WAY_BITS-1:0]      hit_way;
    logic [`ICACHE_WAY_BITS-1:0]      victim;
    logic                             free_found;

    logic [2:0]                       plru [`ICACHE_NUM_SETS]; // root, lower leaf, upper leaf.

    assign tag      = addr[31 -: `ICACHE_TAG_BITS];
    assign set      = addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign word_sel = addr[`ICACHE_OFFSET_BITS-1:2];

    icache_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .kill         (kill),
        .read         (read),
        .tag          (tag),
        .set          (set),
        .tag_entries  (tag_entries),
        .stall        (stall),
        .allocate_done(allocate_done),
        .hit          (hit),
        .hit_way      (hit_way),
        .mem_req      (mem_req),
        .mem_ready    (mem_ready),
        .mem_resp     (mem_resp)
    );

    assign fill_tag.valid = 1'b1;
    assign fill_tag.tag   = tag;

    way_array #(.entry_t(icache_pkg::tag_entry_t)) tag_array_i (
        .clk       (clk),
        .rst       (rst),
        .rd_set    (set),
        .rd_entries(tag_entries),
        .wr_en     (allocate_done),
        .wr_set    (set),
        .wr_way    (victim),
        .wr_entry  (fill_tag)
    );

    way_array #(.entry_t(icache_pkg::line_t)) data_array_i (
        .clk       (clk),
        .rst       (rst),
        .rd_set    (set),
        .rd_entries(data_entries),
        .wr_en     (allocate_done),
        .wr_set    (set),
        .wr_way    (victim),
        .wr_entry  (mem_resp.data)
    );

    assign rdata = data_entries[hit_way][word_sel];

    // mark a way as most recently used.
    function automatic logic [2:0] plru_touch(input logic [2:0] bits,
                                              input logic [`ICACHE_WAY_BITS-1:0] way);
        logic [2:0] next;
        next    = bits;
        next[0] = way[1];
        if (way[1]) begin
            next[2] = way[0];
        end else begin
            next[1] = way[0];
        end
        return next;
    endfunction

    // free way first, then walk away from recent use.
    always_comb begin
        victim     = '0;
        free_found = 1'b0;
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            if (!free_found && !tag_entries[w].valid) begin
                victim     = `ICACHE_WAY_BITS'(w);
                free_found = 1'b1;
            end
        end
        if (!free_found) begin
            if (plru[set][0]) begin
                victim = {1'b0, ~plru[set][1]};
            end else begin
                victim = {1'b1, ~plru[set][2]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
                plru[s] <= '0;
            end
        end else if (allocate_done) begin
            plru[set] <= plru_touch(plru[set], victim);
        end else if (read && hit) begin
            plru[set] <= plru_touch(plru[set], hit_way); // completed fetch.
        end
    end

endmodule

`default_nettype wire

// ==== hw/icache_ctrl.sv ====
`default_nettype none

`include "icache_macros.svh"

module icache_ctrl (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        kill,
    input  logic                        read,
    input  logic [`ICACHE_TAG_BITS-1:0] tag,
    input  logic [`ICACHE_SET_BITS-1:0] set,
    input  icache_pkg::tag_entry_t      tag_entries [`ICACHE_NUM_WAYS],

    output logic                        stall,
    output logic                        allocate_done,
    output logic                        hit,
    output logic [`ICACHE_WAY_BITS-1:0] hit_way,

    output icache_pkg::mem_req_t        mem_req,
    input  logic                        mem_ready,
    input  icache_pkg::mem_resp_t       mem_resp
);

    icache_pkg::ctrl_state_t state;
    icache_pkg::ctrl_state_t next_state;
    logic                    resp_match;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::PASS_THRU;
        end else begin
            state <= next_state;
        end
    end

    assign mem_req.addr = {tag, set, {`ICACHE_OFFSET_BITS{1'b0}}};

    // only the response to our own request counts.
    assign resp_match = mem_resp.valid && (mem_resp.addr == mem_req.addr);

    always_comb begin
        next_state    = state;
        mem_req.read  = 1'b0;
        allocate_done = 1'b0;

        unique case (state)
            icache_pkg::PASS_THRU: begin
                if (!kill && read && !hit) begin
                    mem_req.read = 1'b1; // held until the arbiter says ready.
                    if (mem_ready) begin
                        next_state = icache_pkg::ALLOCATE;
                    end
                end
            end
            icache_pkg::ALLOCATE: begin
                if (kill) begin
                    next_state = icache_pkg::PASS_THRU; // late response is dropped.
                end else if (resp_match) begin
                    allocate_done = 1'b1;
                    next_state    = icache_pkg::ALLOCATE_STALL;
                end
            end
            icache_pkg::ALLOCATE_STALL: begin
                next_state = icache_pkg::PASS_THRU;
            end
            default: begin
                next_state = icache_pkg::PASS_THRU;
            end
        endcase
    end

    // tag compare across all ways of the set.
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            if (tag_entries[w].valid && tag_entries[w].tag == tag) begin
                hit     = 1'b1;
                hit_way = `ICACHE_WAY_BITS'(w);
            end
        end
    end

    assign stall = read && !hit;

endmodule

`default_nettype wire

// ==== hw/icache_macros.svh ====
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry.
`define ICACHE_NUM_WAYS 4
`define ICACHE_WAY_BITS 2
`define ICACHE_NUM_SETS 32
`define ICACHE_SET_BITS 5

// address split into tag, set and byte offset.
`define ICACHE_OFFSET_BITS 5
`define ICACHE_TAG_BITS 22

// one line is eight 32-bit instruction words.
`define ICACHE_LINE_WORDS 8

// fetch ports sharing the memory port.
`define ICACHE_NUM_PORTS 2

`endif

// ==== hw/icache_pkg.sv ====
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

    typedef enum logic [1:0] {
        PASS_THRU      = 2'd0,
        ALLOCATE       = 2'd1,
        ALLOCATE_STALL = 2'd2
    } ctrl_state_t;

    typedef logic [31:0] word_t;

    typedef word_t [`ICACHE_LINE_WORDS-1:0] line_t; // word 0 in the low bits.

    typedef struct packed {
        logic                        valid;
        logic [`ICACHE_TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic        read;
        logic [31:0] addr; // offset bits are zero.
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        line_t       data;
    } mem_resp_t;

endpackage

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
`default_nettype none

`include "icache_macros.svh"

module mem_arbiter (
    input  logic                         clk,
    input  logic                         rst,

    input  icache_pkg::mem_req_t         req_in [`ICACHE_NUM_PORTS],
    output logic [`ICACHE_NUM_PORTS-1:0] ready_out,

    output icache_pkg::mem_req_t         mem_req,
    input  logic                         mem_ready
);

    logic last; // port accepted most recently.
    logic gnt;
    logic accepted;

    // the port served last loses a tie.
    always_comb begin
        if (req_in[0].read && req_in[1].read) begin
            gnt = ~last;
        end else if (req_in[1].read) begin
            gnt = 1'b1;
        end else begin
            gnt = 1'b0;
        end
    end

    assign mem_req  = req_in[gnt];
    assign accepted = mem_req.read && mem_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            last <= 1'b1; // port 0 wins the first tie.
        end else if (accepted) begin
            last <= gnt;
        end
    end

    always_comb begin
        ready_out      = '0;
        ready_out[gnt] = mem_ready;
    end

endmodule

`default_nettype wire

// ==== hw/way_array.sv ====
`default_nettype none

`include "icache_macros.svh"

module way_array #(
    parameter type entry_t = logic
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic [`ICACHE_SET_BITS-1:0] rd_set,
    output entry_t                      rd_entries [`ICACHE_NUM_WAYS],

    input  logic                        wr_en,
    input  logic [`ICACHE_SET_BITS-1:0] wr_set,
    input  logic [`ICACHE_WAY_BITS-1:0] wr_way,
    input  entry_t                      wr_entry
);

    entry_t mem [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
                for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
                    mem[s][w] <= '0;
                end
            end
        end else if (wr_en) begin
            mem[wr_set][wr_way] <= wr_entry; // one way per edge.
        end
    end

    // whole set visible at once for the tag compare and word select.
    always_comb begin
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            rd_entries[w] = mem[rd_set][w];
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f filelist.f --top-module fetch_tb -o fetch_sim

out=$(./obj_dir/fetch_sim)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// ==== verif/fetch_tb.sv ====
`default_nettype none

`include "icache_macros.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS    = 5;
    localparam int RANDOM_PAIRS = 30;
    localparam int POOL_SIZE    = 4096;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [1:0]            read;
    logic [1:0]            kill;
    logic [31:0]           addr [2];
    logic [1:0]            stall;
    icache_pkg::word_t     rdata [2];
    icache_pkg::mem_req_t  mem_req;
    logic                  mem_ready;
    icache_pkg::mem_resp_t mem_resp;

    int                    seed = 32'h53d3;
    int unsigned           rand_pool [POOL_SIZE];
    int                    pool_idx;
    int                    cycle_count;
    logic                  ready_hold = 1'b0;
    logic                  acc_now = 1'b0;
    icache_pkg::mem_req_t  acc_req;
    icache_pkg::mem_req_t  req_log [$]; // every accepted request, in order.
    logic [31:0]           pend_addr [$];
    int                    pend_due [$];

    logic                        model_valid [2][`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    logic [`ICACHE_TAG_BITS-1:0] model_tag [2][`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    logic [2:0]                  model_plru [2][`ICACHE_NUM_SETS]; // root, lower leaf, upper leaf.

    string cur_test;
    int    test_checks;
    int    test_errors;
    int    tests_run;
    int    tests_failed;
    int    total_errors;

    fetch_top dut_i (.*);

    always #20 clk = ~clk;

    // requests are sampled mid-cycle, where they are stable.
    always @(negedge clk) begin
        acc_now = mem_req.read && mem_ready;
        acc_req = mem_req;
    end

    // memory model with at most one response pulse per cycle.
    initial begin
        icache_pkg::mem_resp_t resp;
        int                    pick;
        mem_ready <= 1'b0;
        mem_resp  <= '0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (acc_now) begin
                req_log.push_back(acc_req);
                pend_addr.push_back(acc_req.addr);
                pend_due.push_back(cycle_count + 1 + int'(rand_pool[pool_idx % POOL_SIZE] % 8));
                pool_idx++;
            end
            resp = '0;
            pick = -1;
            for (int i = 0; i < pend_due.size(); i++) begin
                if (pick < 0 && pend_due[i] <= cycle_count)
                    pick = i;
            end
            if (pick >= 0) begin
                resp.valid = 1'b1;
                resp.addr  = pend_addr[pick];
                resp.data  = make_line(pend_addr[pick]);
                pend_addr.delete(pick);
                pend_due.delete(pick);
            end
            mem_resp  <= resp;
            mem_ready <= ready_hold || (rand_pool[pool_idx % POOL_SIZE] % 4 != 0);
            pool_idx++;
        end
    end

    function automatic icache_pkg::line_t make_line(input logic [31:0] line_addr);
        icache_pkg::line_t ln;
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++)
            ln[i] = (line_addr + 32'(4 * i)) ^ 32'hc0de0000;
        return ln;
    endfunction

    function automatic icache_pkg::word_t expected_word(input logic [31:0] a);
        return ((a & 32'hffff_ffe0) + {27'd0, a[4:2], 2'b00}) ^ 32'hc0de0000;
    endfunction

    function automatic logic [31:0] random_addr(input int p);
        logic [`ICACHE_TAG_BITS-1:0] tag;
        tag = {13'd0, 5'(p), 4'($unsigned($random(seed)))}; // 16 tags per port.
        return {tag, 3'd0, 2'($unsigned($random(seed))), 3'($unsigned($random(seed))), 2'b00};
    endfunction

    function automatic int count_reqs(input int from, input logic [31:0] line_addr);
        int n = 0;
        for (int i = from; i < req_log.size(); i++)
            if (req_log[i].addr == line_addr)
                n++;
        return n;
    endfunction

    // hit way of the model or -1 on a miss.
    function automatic int model_way(input int p, input logic [31:0] a);
        int s;
        s = int'(a[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS]);
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++)
            if (model_valid[p][s][w] && model_tag[p][s][w] == a[31 -: `ICACHE_TAG_BITS])
                return w;
        return -1;
    endfunction

    task automatic model_fetch(input int p, input logic [31:0] a);
        int         s;
        int         w;
        logic [2:0] b;
        s = int'(a[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS]);
        w = model_way(p, a);
        b = model_plru[p][s];
        if (w < 0) begin
            for (int i = `ICACHE_NUM_WAYS - 1; i >= 0; i--)
                if (!model_valid[p][s][i])
                    w = i;
            if (w < 0)
                w = b[0] ? (b[1] ? 0 : 1) : (b[2] ? 2 : 3); // away from recent use.
            model_valid[p][s][w] = 1'b1;
            model_tag[p][s][w]   = a[31 -: `ICACHE_TAG_BITS];
        end
        b[0] = (w >= 2);
        if (w >= 2)
            b[2] = (w == 3);
        else
            b[1] = (w == 1);
        model_plru[p][s] = b;
    endtask

    task automatic model_clear();
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
                model_plru[p][s] = '0;
                for (int w = 0; w < `ICACHE_NUM_WAYS; w++)
                    model_valid[p][s][w] = 1'b0;
            end
        end
    endtask

    task automatic check_word(input string what, input icache_pkg::word_t exp,
                              input icache_pkg::word_t act);
        test_checks++;
        if (exp !== act) begin
            test_errors++;
            $display("error %s, %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_req(input string what, input icache_pkg::mem_req_t exp,
                             input icache_pkg::mem_req_t act);
        test_checks++;
        if (exp !== act) begin
            test_errors++;
            $display("error %s, %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        test_checks++;
        if (exp !== act) begin
            test_errors++;
            $display("error %s, %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        total_errors += test_errors;
        $display("test %s done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    endtask

    task automatic do_reset();
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        model_clear();
    endtask

    task automatic drain_memory();
        do @(negedge clk); while (pend_addr.size() != 0 || mem_resp.valid);
        @(posedge clk);
    endtask

    // start a fetch on each enabled port at once and run until both complete.
    task automatic fetch_pair(input logic [1:0] en, input logic [31:0] a0, input logic [31:0] a1,
                              output logic [1:0] first_stall, output int log_start);
        logic [31:0] a [2];
        logic [1:0]  done;
        logic [1:0]  miss;
        logic        first;
        a[0] = a0;
        a[1] = a1;
        @(negedge clk);
        log_start = req_log.size();
        for (int p = 0; p < 2; p++)
            miss[p] = en[p] && model_way(p, a[p]) < 0;
        @(posedge clk);
        read    <= en;
        addr[0] <= a0;
        addr[1] <= a1;
        done        = ~en;
        first       = 1'b1;
        first_stall = '0;
        while (done != 2'b11) begin
            @(negedge clk);
            for (int p = 0; p < 2; p++) begin
                if (!done[p]) begin
                    if (first) begin
                        first_stall[p] = stall[p];
                        check_bit($sformatf("port %0d first-cycle stall", p), miss[p], stall[p]);
                    end
                    if (!stall[p]) begin
                        done[p] = 1'b1;
                        check_word($sformatf("port %0d word at %h", p, a[p]),
                                   expected_word(a[p]), rdata[p]);
                        if (count_reqs(log_start, a[p] & 32'hffff_ffe0) != int'(miss[p])) begin
                            test_errors++;
                            $display("%s: port %0d fetch at %h did not see %0d memory request(s)",
                                     cur_test, p, a[p], int'(miss[p]));
                        end
                        model_fetch(p, a[p]);
                    end
                end
            end
            first = 1'b0;
            @(posedge clk);
            read <= en & ~done;
        end
    endtask

    initial begin
        logic [1:0]  fs;
        int          ls;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] ka;
        read    <= '0;
        kill    <= '0;
        addr[0] <= '0;
        addr[1] <= '0;
        foreach (rand_pool[i])
            rand_pool[i] = $unsigned($random(seed));
        do_reset();

        start_test("reset_idle");
        repeat (8) begin
            @(negedge clk);
            check_bit("port 0 stall", 1'b0, stall[0]);
            check_bit("port 1 stall", 1'b0, stall[1]);
            check_bit("memory read", 1'b0, mem_req.read);
        end
        finish_test();

        start_test("random_fetch");
        repeat (RANDOM_PAIRS)
            fetch_pair(2'b11, random_addr(0), random_addr(1), fs, ls);
        finish_test();

        start_test("evict_oldest");
        for (int i = 0; i < 5; i++)
            fetch_pair(2'b01, {22'(32'h200 + i), 5'd9, 5'd0}, 32'd0, fs, ls);
        fetch_pair(2'b01, {22'h200, 5'd9, 5'd8}, 32'd0, fs, ls);
        check_bit("refetch of first tag stalls", 1'b1, fs[0]);
        finish_test();

        drain_memory();
        do_reset();
        start_test("arbiter_alternation");
        ready_hold = 1'b1;
        for (int r = 0; r < 2; r++) begin
            a0 = {22'(32'h300 + r), 5'd3, 5'd0};
            a1 = {22'(32'h310 + r), 5'd3, 5'd0};
            fetch_pair(2'b11, a0, a1, fs, ls);
            check_req("first request", icache_pkg::mem_req_t'({1'b1, a0}), req_log[ls]);
            check_req("second request", icache_pkg::mem_req_t'({1'b1, a1}), req_log[ls + 1]);
        end
        ready_hold = 1'b0;
        finish_test();

        start_test("kill_pending_miss");
        ka = {22'h3f0, 5'd7, 5'd4};
        @(negedge clk);
        ls = req_log.size();
        @(posedge clk);
        read    <= 2'b01;
        addr[0] <= ka;
        do @(negedge clk); while (count_reqs(ls, ka & 32'hffff_ffe0) == 0);
        @(posedge clk);
        read <= 2'b00;
        kill <= 2'b01; // redirect while the line is in flight.
        @(posedge clk);
        kill <= 2'b00;
        drain_memory();
        fetch_pair(2'b01, ka, 32'd0, fs, ls);
        check_bit("killed line stalls again", 1'b1, fs[0]);
        finish_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * 40);
        $display("watchdog: the tests did not finish within their time limit");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
